/* Makefile */
# Verilator build and run for the MX integer adder

VERILATOR ?= verilator
TOP       ?= tb_mxint_add
FILELIST  ?= mxint_add.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= STATUS: PASS

SOURCES := $(wildcard common/*.sv common/*.svh logic/*.sv mxint_addition/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/mxint_macros.svh */
`ifndef MXINT_MACROS_SVH
`define MXINT_MACROS_SVH

// Elements that share one exponent
`define MXINT_BLOCK_SIZE 4

// Signed mantissa width of one element
`define MXINT_MAN_WIDTH 8

// Signed shared exponent width, same on inputs and output
`define MXINT_EXP_WIDTH 8

// Element sum before the cast, one carry bit wider
`define MXINT_SUM_WIDTH (`MXINT_MAN_WIDTH + 1)

`endif

/* common/mxint_pkg.sv */
`include "mxint_macros.svh"

package mxint_pkg;

  typedef logic signed [`MXINT_MAN_WIDTH-1:0] mantissa_t;
  typedef logic signed [`MXINT_SUM_WIDTH-1:0] sum_mantissa_t;
  typedef logic signed [`MXINT_EXP_WIDTH-1:0] exponent_t;

  // Element 0 sits in the low bits
  typedef mantissa_t [`MXINT_BLOCK_SIZE-1:0] mantissa_array_t;
  typedef sum_mantissa_t [`MXINT_BLOCK_SIZE-1:0] sum_mantissa_array_t;

  // One MX integer block
  typedef struct packed {
    exponent_t       exponent;
    mantissa_array_t mantissa;
  } mxint_block_t;

  // Aligned sums, not yet renormalized
  typedef struct packed {
    exponent_t           exponent;
    sum_mantissa_array_t mantissa;
  } mxint_sum_t;

endpackage

/* logic/mxint_add_top.sv */
`timescale 1ns/1ns
`include "mxint_macros.svh"

module mxint_add_top (
  input  logic                    clk,
  input  logic                    reset,
  input  mxint_pkg::mxint_block_t a_data,
  input  logic                    a_valid,
  output logic                    a_ready,
  input  mxint_pkg::mxint_block_t b_data,
  input  logic                    b_valid,
  output logic                    b_ready,
  output mxint_pkg::mxint_block_t result_data,
  output logic                    result_valid,
  input  logic                    result_ready
);

  mxint_pkg::mxint_block_t skid_a_data;
  logic                    skid_a_valid;
  logic                    skid_a_ready;
  mxint_pkg::mxint_block_t skid_b_data;
  logic                    skid_b_valid;
  logic                    skid_b_ready;

  mxint_skid_buffer #(.payload_t(mxint_pkg::mxint_block_t)) skid_a (
    .clk       (clk),
    .reset     (reset),
    .in_data   (a_data),
    .in_valid  (a_valid),
    .in_ready  (a_ready),
    .out_data  (skid_a_data),
    .out_valid (skid_a_valid),
    .out_ready (skid_a_ready)
  );

  mxint_skid_buffer #(.payload_t(mxint_pkg::mxint_block_t)) skid_b (
    .clk       (clk),
    .reset     (reset),
    .in_data   (b_data),
    .in_valid  (b_valid),
    .in_ready  (b_ready),
    .out_data  (skid_b_data),
    .out_valid (skid_b_valid),
    .out_ready (skid_b_ready)
  );

  mxint_addition adder (
    .clk       (clk),
    .reset     (reset),
    .a_data    (skid_a_data),
    .a_valid   (skid_a_valid),
    .a_ready   (skid_a_ready),
    .b_data    (skid_b_data),
    .b_valid   (skid_b_valid),
    .b_ready   (skid_b_ready),
    .sum_data  (result_data),
    .sum_valid (result_valid),
    .sum_ready (result_ready)
  );

endmodule

/* logic/mxint_skid_buffer.sv */
`timescale 1ns/1ns
`include "mxint_macros.svh"

module mxint_skid_buffer #(
  parameter type payload_t = logic [`MXINT_MAN_WIDTH-1:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t main_data;
  logic     main_valid;
  payload_t skid_data;
  logic     skid_valid;
  logic     main_free;
  logic     in_fire;

  assign main_free = !main_valid || out_ready; // Main can take a new item
  assign in_fire   = in_valid && in_ready;

  // Ready only drops with both entries full
  assign in_ready  = !skid_valid;
  assign out_data  = main_data;
  assign out_valid = main_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      if (skid_valid) begin
        main_valid <= 1'b1; // Drain the skid entry first
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_valid;
      end
    end else if (in_fire) begin
      skid_valid <= 1'b1; // Output stalled, park it
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      main_data <= skid_valid ? skid_data : in_data;
    end
    if (in_fire && !main_free) begin
      skid_data <= in_data;
    end
  end

  // Held item must not move under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("skid buffer output changed while stalled");

endmodule

/* mxint_add.f */
+incdir+common
common/mxint_pkg.sv
logic/mxint_skid_buffer.sv
mxint_addition/mxint_align_shift.sv
mxint_addition/mxint_cast.sv
mxint_addition/mxint_addition.sv
logic/mxint_add_top.sv
sim/tb_mxint_add.sv

/* mxint_addition/mxint_addition.sv */
`timescale 1ns/1ns
`include "mxint_macros.svh"

module mxint_addition (
  input  logic                    clk,
  input  logic                    reset,
  input  mxint_pkg::mxint_block_t a_data,
  input  logic                    a_valid,
  output logic                    a_ready,
  input  mxint_pkg::mxint_block_t b_data,
  input  logic                    b_valid,
  output logic                    b_ready,
  output mxint_pkg::mxint_block_t sum_data,
  output logic                    sum_valid,
  input  logic                    sum_ready
);

  logic                           join_valid;
  logic                           cast_ready;
  mxint_pkg::exponent_t           max_exp;
  logic [`MXINT_EXP_WIDTH-1:0]    shift_a;
  logic [`MXINT_EXP_WIDTH-1:0]    shift_b;
  mxint_pkg::mantissa_array_t     aligned_a;
  mxint_pkg::mantissa_array_t     aligned_b;
  mxint_pkg::mxint_sum_t          sum_raw;

  // Both sides move on the same edge
  assign join_valid = a_valid && b_valid;
  assign a_ready    = cast_ready && b_valid;
  assign b_ready    = cast_ready && a_valid;

  assign max_exp = (a_data.exponent > b_data.exponent) ? a_data.exponent : b_data.exponent;
  assign shift_a = max_exp - a_data.exponent; // Never negative
  assign shift_b = max_exp - b_data.exponent;

  mxint_align_shift align_a (
    .mantissa_in  (a_data.mantissa),
    .shift        (shift_a),
    .mantissa_out (aligned_a)
  );

  mxint_align_shift align_b (
    .mantissa_in  (b_data.mantissa),
    .shift        (shift_b),
    .mantissa_out (aligned_b)
  );

  // Sign extend into the carry bit before adding
  always_comb begin
    sum_raw.exponent = max_exp;
    for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
      sum_raw.mantissa[i] = mxint_pkg::sum_mantissa_t'(aligned_a[i]) +
                            mxint_pkg::sum_mantissa_t'(aligned_b[i]);
    end
  end

  mxint_cast cast (
    .clk       (clk),
    .reset     (reset),
    .sum_in    (sum_raw),
    .in_valid  (join_valid),
    .in_ready  (cast_ready),
    .block_out (sum_data),
    .out_valid (sum_valid),
    .out_ready (sum_ready)
  );

endmodule

/* mxint_addition/mxint_align_shift.sv */
`timescale 1ns/1ns
`include "mxint_macros.svh"

module mxint_align_shift (
  input  mxint_pkg::mantissa_array_t         mantissa_in,
  input  logic [`MXINT_EXP_WIDTH-1:0]        shift,
  output mxint_pkg::mantissa_array_t         mantissa_out
);

  logic shift_saturated;

  // Past the mantissa width only the sign survives
  assign shift_saturated = shift >= `MXINT_MAN_WIDTH;

  always_comb begin
    for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
      if (shift_saturated) begin
        mantissa_out[i] = {`MXINT_MAN_WIDTH{mantissa_in[i][`MXINT_MAN_WIDTH-1]}};
      end else begin
        mantissa_out[i] = mantissa_in[i] >>> shift; // Truncates toward minus infinity
      end
    end
  end

endmodule

/* mxint_addition/mxint_cast.sv */
`timescale 1ns/1ns
`include "mxint_macros.svh"

module mxint_cast (
  input  logic                    clk,
  input  logic                    reset,
  input  mxint_pkg::mxint_sum_t   sum_in,
  input  logic                    in_valid,
  output logic                    in_ready,
  output mxint_pkg::mxint_block_t block_out,
  output logic                    out_valid,
  input  logic                    out_ready
);

  localparam mxint_pkg::exponent_t exp_max = {1'b0, {(`MXINT_EXP_WIDTH-1){1'b1}}};
  localparam mxint_pkg::mantissa_t man_max = {1'b0, {(`MXINT_MAN_WIDTH-1){1'b1}}};
  localparam mxint_pkg::mantissa_t man_min = {1'b1, {(`MXINT_MAN_WIDTH-1){1'b0}}};

  logic [`MXINT_BLOCK_SIZE-1:0] elem_overflow;
  logic                         any_overflow;
  logic                         at_max;
  logic                         renormalize;
  mxint_pkg::mxint_block_t      cast_block;
  mxint_pkg::mxint_block_t      out_reg;
  logic                         out_valid_reg;

  // Top two bits differ when the sum leaves the output range
  always_comb begin
    for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
      elem_overflow[i] = sum_in.mantissa[i][`MXINT_MAN_WIDTH] !=
                         sum_in.mantissa[i][`MXINT_MAN_WIDTH-1];
    end
  end

  assign any_overflow = |elem_overflow;
  assign at_max       = sum_in.exponent == exp_max;
  assign renormalize  = any_overflow && !at_max;

  always_comb begin
    cast_block.exponent = renormalize ? sum_in.exponent + 1'b1 : sum_in.exponent;
    for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
      if (renormalize) begin
        // Whole block drops one bit
        cast_block.mantissa[i] = sum_in.mantissa[i][`MXINT_MAN_WIDTH:1];
      end else if (elem_overflow[i]) begin
        // Exponent already at max, clamp
        cast_block.mantissa[i] = sum_in.mantissa[i][`MXINT_MAN_WIDTH] ? man_min : man_max;
      end else begin
        cast_block.mantissa[i] = sum_in.mantissa[i][`MXINT_MAN_WIDTH-1:0];
      end
    end
  end

  // Take a new item when empty or draining this cycle
  assign in_ready = !out_valid_reg || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid_reg <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid_reg <= 1'b1;
    end else if (out_ready) begin
      out_valid_reg <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_reg <= cast_block;
    end
  end

  assign block_out = out_reg;
  assign out_valid = out_valid_reg;

  assert property (@(posedge clk) reset |=> !out_valid)
    else $error("cast output valid after reset");

  // Stalled result keeps its value until taken
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(block_out))
    else $error("cast output changed while stalled");

endmodule

/* sim/tb_mxint_add.sv */
`timescale 1ns/1ns
`include "mxint_macros.svh"

module tb_mxint_add;

  localparam int MAN_MAX      = (1 << (`MXINT_MAN_WIDTH - 1)) - 1;
  localparam int MAN_MIN      = -(1 << (`MXINT_MAN_WIDTH - 1));
  localparam int EXP_MAX      = (1 << (`MXINT_EXP_WIDTH - 1)) - 1;
  localparam int EXP_MIN      = -(1 << (`MXINT_EXP_WIDTH - 1));
  localparam int RANDOM_PAIRS = 200;
  localparam int TOTAL_PAIRS  = 4 + 8 + 4 + 4 + 1 + RANDOM_PAIRS;
  localparam int CYCLE_LIMIT  = 4 * TOTAL_PAIRS + 200;

  logic                    clk;
  logic                    reset;
  mxint_pkg::mxint_block_t a_data;
  logic                    a_valid;
  logic                    a_ready;
  mxint_pkg::mxint_block_t b_data;
  logic                    b_valid;
  logic                    b_ready;
  mxint_pkg::mxint_block_t result_data;
  logic                    result_valid;
  logic                    result_ready;

  integer                  seed;
  mxint_pkg::mxint_block_t a_stim[$];
  mxint_pkg::mxint_block_t b_stim[$];
  mxint_pkg::mxint_block_t a_seen[$];
  mxint_pkg::mxint_block_t b_seen[$];
  mxint_pkg::mxint_block_t expected_q[$];
  mxint_pkg::mxint_block_t exp_head;
  logic                    exp_avail;
  mxint_pkg::mxint_block_t held_data;
  logic                    stalled_q;
  logic                    random_ready;
  logic                    probe_en;
  logic                    probe_d1;
  logic                    probe_d2;
  int                      pairs_queued;
  int                      results_seen;
  int                      cycles;

  mxint_add_top UUT (
    .clk          (clk),
    .reset        (reset),
    .a_data       (a_data),
    .a_valid      (a_valid),
    .a_ready      (a_ready),
    .b_data       (b_data),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  always #50 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic mxint_pkg::mxint_block_t rand_block(input int e, input int lo, input int hi);
    mxint_pkg::mxint_block_t blk;
    blk.exponent = mxint_pkg::exponent_t'(e);
    for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
      blk.mantissa[i] = mxint_pkg::mantissa_t'(rand_range(lo, hi));
    end
    return blk;
  endfunction

  // Arithmetic shift, only sign left past the width
  function automatic int align_mantissa(input int m, input int gap);
    if (gap >= `MXINT_MAN_WIDTH) begin
      return (m < 0) ? -1 : 0;
    end
    return m >>> gap;
  endfunction

  function automatic mxint_pkg::mxint_block_t expected_sum(input mxint_pkg::mxint_block_t a,
                                                           input mxint_pkg::mxint_block_t b);
    mxint_pkg::mxint_block_t r;
    int sums[`MXINT_BLOCK_SIZE];
    int ea;
    int eb;
    int emax;
    bit overflow;
    ea = int'(a.exponent);
    eb = int'(b.exponent);
    emax = (ea > eb) ? ea : eb;
    overflow = 1'b0;
    for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
      sums[i] = align_mantissa(int'(a.mantissa[i]), emax - ea) +
                align_mantissa(int'(b.mantissa[i]), emax - eb);
      if (sums[i] > MAN_MAX || sums[i] < MAN_MIN) begin
        overflow = 1'b1;
      end
    end
    if (overflow && emax < EXP_MAX) begin
      emax = emax + 1;
      for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
        sums[i] = sums[i] >>> 1; // Floor halving
      end
    end else if (overflow) begin
      for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
        sums[i] = (sums[i] > MAN_MAX) ? MAN_MAX : (sums[i] < MAN_MIN) ? MAN_MIN : sums[i];
      end
    end
    r.exponent = mxint_pkg::exponent_t'(emax);
    for (int i = 0; i < `MXINT_BLOCK_SIZE; i++) begin
      r.mantissa[i] = mxint_pkg::mantissa_t'(sums[i]);
    end
    return r;
  endfunction

  task automatic queue_pair(input mxint_pkg::mxint_block_t a, input mxint_pkg::mxint_block_t b);
    a_stim.push_back(a);
    b_stim.push_back(b);
    pairs_queued++;
  endtask

  // One input stream, holds valid until taken
  task automatic drive_side(input bit side_b, input int gap_pct);
    int next;
    int count;
    bit offering;
    next = 0;
    offering = 1'b0;
    count = side_b ? b_stim.size() : a_stim.size();
    while (next < count || offering) begin
      @(posedge clk);
      if (offering && (side_b ? b_ready : a_ready)) begin
        offering = 1'b0;
      end
      if (!offering) begin
        if (next < count && rand_range(0, 99) >= gap_pct) begin
          if (side_b) begin
            b_data  <= b_stim[next];
            b_valid <= 1'b1;
          end else begin
            a_data  <= a_stim[next];
            a_valid <= 1'b1;
          end
          offering = 1'b1;
          next++;
        end else if (side_b) begin
          b_valid <= 1'b0;
        end else begin
          a_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic run_phase(input int gap_pct);
    fork
      drive_side(1'b0, gap_pct);
      drive_side(1'b1, gap_pct);
    join
    while (results_seen < pairs_queued) begin
      @(posedge clk);
    end
    a_stim.delete();
    b_stim.delete();
  endtask

  // Pairs inputs in order and tracks the DUT output
  always @(posedge clk) begin
    if (!reset) begin
      if (a_valid && a_ready) a_seen.push_back(a_data);
      if (b_valid && b_ready) b_seen.push_back(b_data);
      while (a_seen.size() > 0 && b_seen.size() > 0) begin
        expected_q.push_back(expected_sum(a_seen.pop_front(), b_seen.pop_front()));
      end
      if (result_valid && result_ready && expected_q.size() > 0) begin
        void'(expected_q.pop_front());
        results_seen <= results_seen + 1;
      end
      exp_avail <= expected_q.size() > 0;
      if (expected_q.size() > 0) exp_head <= expected_q[0];
    end
    probe_d1  <= probe_en && a_valid && a_ready && b_valid && b_ready;
    probe_d2  <= probe_d1;
    stalled_q <= !reset && result_valid && !result_ready;
    held_data <= result_data;
  end

  always @(posedge clk) begin
    if (random_ready) begin
      result_ready <= rand_range(0, 9) < 7;
    end else begin
      result_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      report_failure($sformatf("Timeout after %0d cycles, results did not finish (%0d of %0d)",
                               cycles, results_seen, TOTAL_PAIRS));
    end
  end

  assert property (@(posedge clk) $fell(reset) |-> !result_valid && a_ready && b_ready)
    else report_failure("outputs were not idle and ready right after reset");

  assert property (@(posedge clk) disable iff (reset)
    result_valid && result_ready |-> exp_avail)
    else report_failure("a result came out with no input pair left to match it");

  assert property (@(posedge clk) disable iff (reset)
    result_valid && result_ready && exp_avail |-> result_data == exp_head)
    else report_failure($sformatf("Error: time %0t result_data expected %h actual %h",
                                  $time, $sampled(exp_head), $sampled(result_data)));

  assert property (@(posedge clk) disable iff (reset) stalled_q |-> result_valid)
    else report_failure("result_valid dropped before the stalled result was taken");

  assert property (@(posedge clk) disable iff (reset)
    stalled_q |-> result_data == held_data)
    else report_failure($sformatf("Error: time %0t result_data expected %h actual %h",
                                  $time, $sampled(held_data), $sampled(result_data)));

  // Two cycle latency, empty pipe and no back-pressure
  assert property (@(posedge clk) disable iff (reset) probe_d1 |-> !result_valid)
    else report_failure("result_valid rose one cycle after the input transfers");

  assert property (@(posedge clk) disable iff (reset) probe_d2 |-> result_valid)
    else report_failure("result_valid was not high two cycles after the input transfers");

  initial begin
    int e;
    int e2;
    int gaps[8] = '{1, 3, 7, 8, 9, 30, 100, 255};
    mxint_pkg::mxint_block_t hi_blk;
    mxint_pkg::mxint_block_t lo_blk;
    seed = 32'he40e;
    clk = 1'b0;
    reset = 1'b1;
    a_data = '0;
    a_valid = 1'b0;
    b_data = '0;
    b_valid = 1'b0;
    result_ready = 1'b0;
    random_ready = 1'b0;
    probe_en = 1'b0;
    probe_d1 = 1'b0;
    probe_d2 = 1'b0;
    stalled_q = 1'b0;
    held_data = '0;
    exp_head = '0;
    exp_avail = 1'b0;
    pairs_queued = 0;
    results_seen = 0;
    cycles = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // Equal exponents, sums stay in range
    for (int k = 0; k < 4; k++) begin
      e = rand_range(-20, 20);
      queue_pair(rand_block(e, MAN_MIN / 2, MAN_MAX / 2), rand_block(e, MAN_MIN / 2, MAN_MAX / 2));
    end
    run_phase(20);

    for (int k = 0; k < 8; k++) begin
      e = (gaps[k] > 200) ? EXP_MAX : 60;
      hi_blk = rand_block(e, MAN_MIN / 2, MAN_MAX / 2);
      lo_blk = rand_block(e - gaps[k], MAN_MIN, MAN_MAX);
      if (k % 2 == 1) queue_pair(hi_blk, lo_blk);
      else queue_pair(lo_blk, hi_blk);
    end
    run_phase(20);

    // Overflow renormalizes the whole block
    e = rand_range(-30, 30);
    queue_pair(rand_block(e, 100, MAN_MAX), rand_block(e, 64, MAN_MAX));
    queue_pair(rand_block(e, MAN_MIN, -100), rand_block(e, MAN_MIN, -65));
    hi_blk = rand_block(e, -30, 30);
    lo_blk = rand_block(e, -30, 30);
    hi_blk.mantissa[0] = mxint_pkg::mantissa_t'(120);
    lo_blk.mantissa[0] = mxint_pkg::mantissa_t'(100);
    queue_pair(hi_blk, lo_blk);
    queue_pair(rand_block(e, 100, MAN_MAX), rand_block(e + 1, 100, MAN_MAX));
    run_phase(20);

    queue_pair(rand_block(EXP_MAX, 100, MAN_MAX), rand_block(EXP_MAX, 64, MAN_MAX));
    queue_pair(rand_block(EXP_MAX, MAN_MIN, -100), rand_block(EXP_MAX, MAN_MIN, -65));
    queue_pair(rand_block(EXP_MAX, 90, MAN_MAX), rand_block(EXP_MAX - 1, 100, MAN_MAX));
    queue_pair(rand_block(EXP_MAX - 1, 100, MAN_MAX), rand_block(EXP_MAX - 1, 100, MAN_MAX));
    run_phase(20);

    probe_en <= 1'b1;
    queue_pair(rand_block(0, MAN_MIN / 2, MAN_MAX / 2), rand_block(0, MAN_MIN / 2, MAN_MAX / 2));
    run_phase(0);
    probe_en <= 1'b0;

    random_ready <= 1'b1;
    for (int k = 0; k < RANDOM_PAIRS; k++) begin
      e = rand_range(EXP_MIN, EXP_MAX);
      e2 = e + rand_range(-10, 10);
      if (e2 > EXP_MAX) e2 = EXP_MAX;
      if (e2 < EXP_MIN) e2 = EXP_MIN;
      queue_pair(rand_block(e, MAN_MIN, MAN_MAX), rand_block(e2, MAN_MIN, MAN_MAX));
    end
    run_phase(30);
    random_ready <= 1'b0;

    if (results_seen == TOTAL_PAIRS && expected_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      report_failure($sformatf("run ended with %0d of %0d results and %0d still expected",
                               results_seen, TOTAL_PAIRS, expected_q.size()));
    end
  end

endmodule
